//--- decodePkg.sv
// ====================================================================
// Decode package
// Operating mode, the fetched window and the decoded operand bundle
// ====================================================================
`include "qdec_defs.svh"

package decodePkg;
	import isaPkg::*;

	typedef logic [1:0] operatingMode_t;

	// Six fetched words plus the extension mask left by an earlier prefix
	// regx bit 0 is the store source, bit 1 Ra, bit 2 Rb, bit 3 Rc
	typedef struct packed {
		instr_t [`QDEC_WINDOW-1:0] insn;
		logic [3:0]                regx;
		operatingMode_t            om;
	} window_t;

	typedef struct packed {
		aregno_t     Ra;
		aregno_t     Rb;
		aregno_t     Rc;
		logic [2:0]  Rcc;
		logic        hasImma;
		logic        hasImmb;
		logic        hasImmc;
		logic [63:0] immc;
	} decoded_t;

	// Register 63 is the stack pointer, banked per operating mode
	function automatic aregno_t fnSpAlias(input aregno_t r, input operatingMode_t om);
		return (r == aregno_t'(63)) ? aregno_t'(`QDEC_SP_BASE) + aregno_t'(om) : r;
	endfunction

endpackage

//--- decodeRab.sv
// ====================================================================
// Source register decoder for Ra and Rb
// Applies the extension mask and the stack-pointer alias
// ====================================================================
`timescale 1ns/1ps

module decodeRab
	import isaPkg::*, decodePkg::*;
(
	input  window_t win,
	input  logic    hasImma,
	input  logic    hasImmb,
	output aregno_t Ra,
	output aregno_t Rb
);

	// ================================================================
	// Ra from bits 18:13, extended by regx bit 1
	// ================================================================
	always_comb begin
		// An immediate postfix replaces the register, so no read port is needed
		Ra = '0;
		if (!hasImma)
			Ra = fnSpAlias(fnAreg(win.insn[0].ra, win.regx[1]), win.om);
	end

	// ================================================================
	// Rb from bits 24:19, extended by regx bit 2
	// ================================================================
	always_comb begin
		Rb = '0;
		if (!hasImmb)
			Rb = fnSpAlias(fnAreg(win.insn[0].rb, win.regx[2]), win.om);
	end

endmodule

//--- decodeRc.sv
// ====================================================================
// Rc and condition-field decoder
// Covers stores, shifts, R2, the immc form and the register-C postfix
// ====================================================================
`timescale 1ns/1ps

module decodeRc
	import isaPkg::*, decodePkg::*;
(
	input  window_t    win,
	input  logic       hasImmc,
	output aregno_t    Rc,
	output logic [2:0] Rcc
);

	always_comb begin
		Rc = '0;
		Rcc = 3'd0;
		// With an immediate c operand there is no third register read
		if (!hasImmc) begin
			case (win.insn[0].opcode)
			// Stores read their data from the Rt field
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX:
				Rc = fnAreg(win.insn[0].rt, win.regx[0]);
			OP_SHIFT, OP_R2:
				Rc = fnAreg(win.insn[0].rc, win.regx[3]);
			default:
				// immc form puts a short constant where Rc would be
				if (!win.insn[0].immcForm)
					Rc = fnAreg(win.insn[0].rc, win.regx[3]);
			endcase
		end
		// A register-C postfix wins over everything above, stores included
		if (win.insn[1].opcode == OP_REGC) begin
			Rc = aregno_t'(win.insn[1].rt);
			Rcc = win.insn[1][15:13];
		end
		Rc = fnSpAlias(Rc, win.om);
	end

	// Only the register-C postfix carries a condition field
	always_comb begin
		if (win.insn[1].opcode != OP_REGC)
			assert (Rcc == 3'd0)
				else $error("Rcc set without a register-C postfix");
	end

endmodule

//--- decodeTop.sv
// ====================================================================
// Register-operand decode slice, top level
// Input register, combinational operand decoders, output register
// ====================================================================
`timescale 1ns/1ps

module decodeTop
	import decodePkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  logic     inReq,
	input  window_t  inWin,
	output logic     inAck,
	output logic     outReq,
	output decoded_t outBundle,
	input  logic     outAck
);

	// Internal handshake between the two register stages
	logic     stageReq;
	logic     stageAck;
	window_t  heldWin;
	// Each decoder drives its own fields of the bundle
	decoded_t bundle;

	// ================================================================
	// Input stage
	// ================================================================
	handshakeReg #(.T(window_t)) inStage (
		.clk    (clk),
		.arstN  (arstN),
		.upReq  (inReq),
		.upData (inWin),
		.upAck  (inAck),
		.dnReq  (stageReq),
		.dnData (heldWin),
		.dnAck  (stageAck)
	);

	// ================================================================
	// Operand decode
	// ================================================================
	immDecode immDec (
		.win     (heldWin),
		.hasImma (bundle.hasImma),
		.hasImmb (bundle.hasImmb),
		.hasImmc (bundle.hasImmc),
		.immc    (bundle.immc)
	);

	decodeRab rabDec (
		.win     (heldWin),
		.hasImma (bundle.hasImma),
		.hasImmb (bundle.hasImmb),
		.Ra      (bundle.Ra),
		.Rb      (bundle.Rb)
	);

	// The c flag comes from the scan above, the window is not searched twice
	decodeRc rcDec (
		.win     (heldWin),
		.hasImmc (bundle.hasImmc),
		.Rc      (bundle.Rc),
		.Rcc     (bundle.Rcc)
	);

	// ================================================================
	// Output stage
	// ================================================================
	handshakeReg #(.T(decoded_t)) outStage (
		.clk    (clk),
		.arstN  (arstN),
		.upReq  (stageReq),
		.upData (bundle),
		.upAck  (stageAck),
		.dnReq  (outReq),
		.dnData (outBundle),
		.dnAck  (outAck)
	);

endmodule

//--- handshakeReg.sv
// ====================================================================
// Holding register with four-phase req/ack on both sides
// Holds one payload of any type between an upstream and downstream port
// ====================================================================
`timescale 1ns/1ps

module handshakeReg #(
	parameter type T = logic [7:0]
) (
	input  logic clk,
	input  logic arstN,
	input  logic upReq,
	input  T     upData,
	output logic upAck,
	output logic dnReq,
	output T     dnData,
	input  logic dnAck
);

	logic full;
	logic capture;

	// Only take a new word when empty and the previous upstream cycle has closed
	assign capture = upReq && !upAck && !full;

	// ================================================================
	// Phase control
	// ================================================================
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
			upAck <= 1'b0;
			dnReq <= 1'b0;
		end
		else begin
			// On the upstream side ack rises on capture and follows req down
			if (capture) begin
				full <= 1'b1;
				upAck <= 1'b1;
				// Offer at once unless the sink is still closing its last cycle
				dnReq <= !dnAck;
			end
			else if (upAck && !upReq)
				upAck <= 1'b0;
			// On the downstream side a word is gone as soon as the sink acks it
			if (dnReq && dnAck) begin
				dnReq <= 1'b0;
				full <= 1'b0;
			end
			else if (full && !dnReq && !dnAck)
				dnReq <= 1'b1;
		end
	end

	// Payload register
	always_ff @(posedge clk) begin
		if (capture)
			dnData <= upData;
	end

	// The source keeps its data steady for as long as it waits for an ack
	assert property (@(posedge clk) disable iff (!arstN)
		(upReq && !upAck && $past(upReq && !upAck)) |-> $stable(upData))
		else $error("upData changed while the request was pending");

	// An offered word stays offered and unchanged until the sink acknowledges it
	assert property (@(posedge clk) disable iff (!arstN)
		(dnReq && !dnAck) |=> (dnReq && $stable(dnData)))
		else $error("dnReq or dnData changed before the acknowledge");

endmodule

//--- immDecode.sv
// ====================================================================
// Immediate postfix scan
// Flags immediate operands a, b and c and extracts the c immediate
// ====================================================================
`timescale 1ns/1ps
`include "qdec_defs.svh"

module immDecode
	import isaPkg::*, decodePkg::*;
(
	input  window_t     win,
	output logic        hasImma,
	output logic        hasImmb,
	output logic        hasImmc,
	output logic [63:0] immc
);

	always_comb begin
		// Postfix payload, bits 30:7 of the word
		logic [`QDEC_INSN_W-9:0] payload;

		payload = '0;
		hasImma = 1'b0;
		hasImmb = 1'b0;
		hasImmc = 1'b0;
		immc = '0;
		// Slot 0 is the instruction itself, postfixes follow it
		// Walking down lets the lowest OP_IMMC slot win the value
		for (int i = `QDEC_WINDOW - 1; i >= 1; i--) begin
			case (win.insn[i].opcode)
			OP_IMMA:
				hasImma = 1'b1;
			OP_IMMB:
				hasImmb = 1'b1;
			OP_IMMC: begin
				hasImmc = 1'b1;
				payload = win.insn[i][`QDEC_INSN_W-2:7];
				// Sign bit of the payload is bit 30 of the word
				immc = 64'(signed'(payload));
			end
			default: ;
			endcase
		end
	end

endmodule

//--- isaPkg.sv
// ====================================================================
// ISA package
// Instruction-word layout, opcode encodings and register-number type
// ====================================================================
`include "qdec_defs.svh"

package isaPkg;

	// ================================================================
	// Opcodes
	// ================================================================
	typedef enum logic [6:0] {
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_SHIFT = 7'd9,
		OP_STB   = 7'd40,
		OP_STW   = 7'd41,
		OP_STT   = 7'd42,
		OP_STO   = 7'd43,
		OP_STH   = 7'd44,
		OP_STX   = 7'd45,
		// Postfix words that modify the instruction in slot 0
		OP_REGC  = 7'd120,
		OP_IMMA  = 7'd121,
		OP_IMMB  = 7'd122,
		OP_IMMC  = 7'd123
	} opcode_t;

	// ================================================================
	// Instruction word
	// ================================================================
	// The first member sits at the top bit, so the order runs from bit 31 down
	// In a postfix word bits 30:7 carry the immediate payload instead
	typedef struct packed {
		logic       immcForm;
		logic [5:0] rc;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		opcode_t    opcode;
	} instr_t;

	typedef logic [`QDEC_AREG_W-1:0] aregno_t;

	// Widen a 6-bit register field, the extension bit lands on bit 6
	function automatic aregno_t fnAreg(input logic [5:0] fld, input logic ext);
		return aregno_t'({ext, fld});
	endfunction

endpackage

//--- qdec_defs.svh
// ====================================================================
// Register-operand decode slice, global sizing constants
// Window depth, instruction width, register-number width and the
// first renamed stack-pointer register
// ====================================================================
`ifndef QDEC_DEFS_SVH
`define QDEC_DEFS_SVH

// Instruction slots fetched per window
`define QDEC_WINDOW 6

// Width of one instruction word
`define QDEC_INSN_W 32

// Architectural register numbers, bit 6 is the extension bit
`define QDEC_AREG_W 9

// Register 63 aliases to this base plus the operating mode
`define QDEC_SP_BASE 65

`endif

//--- run.sh
#!/usr/bin/env bash
# Build the decode slice testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_decodeTop \
	-f sim.f \
	-o simDecode

./obj_dir/simDecode 2>&1 | tee "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
echo "Simulation finished without failures"

//--- sim.f
+incdir+.
isaPkg.sv
decodePkg.sv
handshakeReg.sv
immDecode.sv
decodeRab.sv
decodeRc.sv
decodeTop.sv
tb_decodeTop.sv

//--- tb_decodeTop.sv
// ======================================================================
// Testbench for the register-operand decode slice
// Random windows go in through four-phase handshakes, and each bundle
// that comes out is compared against a reference decode
// ======================================================================
`timescale 1ns/1ps
`include "qdec_defs.svh"

module tb_decodeTop
	import isaPkg::*, decodePkg::*;
();

	localparam int NUM_WINDOWS = 300;
	localparam int TIMEOUT = 200;

	logic     clk;
	logic     arstN;
	logic     inReq;
	window_t  inWin;
	logic     inAck;
	logic     outReq;
	decoded_t outBundle;
	logic     outAck;

	integer   seed = 32'h94d65284;
	int       errorCount = 0;
	int       receivedCount = 0;
	decoded_t expQ[$];
	decoded_t expB;
	logic     lastOutReq = 1'b0;

	decodeTop DUT (
		.clk       (clk),
		.arstN     (arstN),
		.inReq     (inReq),
		.inWin     (inWin),
		.inAck     (inAck),
		.outReq    (outReq),
		.outBundle (outBundle),
		.outAck    (outAck)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================================
	// Reference decode, built straight from the instruction format
	// ==================================================================
	function automatic decoded_t refDecode(input window_t w);
		decoded_t    d;
		logic [31:0] word0;
		logic [31:0] word1;
		logic [31:0] post;
		logic [8:0]  spReg;
		logic [6:0]  op;
		logic        foundC;
		int          i;
		d = '0;
		foundC = 1'b0;
		word0 = w.insn[0];
		word1 = w.insn[1];
		op = word0[6:0];
		spReg = 9'(`QDEC_SP_BASE) + {7'd0, w.om};
		// Postfixes only count in slots 1 and up, the lowest IMMC slot gives the value
		for (i = 1; i < `QDEC_WINDOW; i++) begin
			post = w.insn[i];
			if (post[6:0] == OP_IMMA)
				d.hasImma = 1'b1;
			if (post[6:0] == OP_IMMB)
				d.hasImmb = 1'b1;
			if (post[6:0] == OP_IMMC && !foundC) begin
				foundC = 1'b1;
				d.hasImmc = 1'b1;
				d.immc = {{40{post[30]}}, post[30:7]};
			end
		end
		if (!d.hasImma)
			d.Ra = {2'b00, w.regx[1], word0[18:13]};
		if (!d.hasImmb)
			d.Rb = {2'b00, w.regx[2], word0[24:19]};
		if (!d.hasImmc) begin
			// Store data comes from the Rt field
			if (op inside {OP_STB, OP_STW, OP_STT, OP_STO, OP_STH, OP_STX})
				d.Rc = {2'b00, w.regx[0], word0[12:7]};
			else if (op == OP_SHIFT || op == OP_R2)
				d.Rc = {2'b00, w.regx[3], word0[30:25]};
			else if (!word0[31])
				d.Rc = {2'b00, w.regx[3], word0[30:25]};
		end
		// Register-C postfix overrides, and its Rt goes in without the extension bit
		if (word1[6:0] == OP_REGC) begin
			d.Rc = {3'b000, word1[12:7]};
			d.Rcc = word1[15:13];
		end
		if (d.Ra == 9'd63)
			d.Ra = spReg;
		if (d.Rb == 9'd63)
			d.Rb = spReg;
		if (d.Rc == 9'd63)
			d.Rc = spReg;
		return d;
	endfunction

	// Slot 0 leans toward stores, shifts, R2 and ADDI
	function automatic logic [6:0] slotZeroOp(input int sel, input logic [6:0] raw);
		if (sel < 6)
			return 7'(OP_STB) + 7'(sel);
		else if (sel < 8)
			return OP_SHIFT;
		else if (sel < 10)
			return OP_R2;
		else if (sel < 12)
			return OP_ADDI;
		return raw;
	endfunction

	// Only slot 1 may carry the register-C postfix
	function automatic logic [6:0] postfixOp(input int slot, input int sel);
		if (slot == 1 && sel < 5)
			return OP_REGC;
		if (sel < 7)
			return OP_IMMA;
		if (sel < 9)
			return OP_IMMB;
		if (sel < 11)
			return OP_IMMC;
		return OP_ADDI;
	endfunction

	task automatic makeWindow(output window_t w);
		logic [31:0] word;
		logic [31:0] rnd;
		int          sel;
		int          i;
		w = '0;
		for (i = 0; i < `QDEC_WINDOW; i++) begin
			word = $random(seed);
			sel = int'($unsigned($random(seed)) % 16);
			if (i == 0)
				word[6:0] = slotZeroOp(sel, word[6:0]);
			else
				word[6:0] = postfixOp(i, sel);
			// Sprinkle register 63 over the fields to hit the stack-pointer alias
			rnd = $random(seed);
			if (rnd[1:0] == 2'd0)
				word[12:7] = 6'd63;
			if (rnd[3:2] == 2'd0)
				word[18:13] = 6'd63;
			if (rnd[5:4] == 2'd0)
				word[24:19] = 6'd63;
			if (rnd[7:6] == 2'd0)
				word[30:25] = 6'd63;
			w.insn[i] = instr_t'(word);
		end
		rnd = $random(seed);
		w.regx = rnd[3:0];
		w.om = rnd[5:4];
	endtask

	// ==================================================================
	// Reporting
	// ==================================================================
	task automatic finishRun();
		$display("Summary: %0d errors, %0d of %0d bundles received",
			errorCount, receivedCount, NUM_WINDOWS);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("TIMEOUT at %0t ns: %s", $time, what);
		errorCount++;
		finishRun();
	endtask

	task automatic checkField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		if (actVal !== expVal) begin
			$display("CHECK FAILED t=%0t %s expected %0h actual %0h",
				$time, name, expVal, actVal);
			errorCount++;
		end
	endtask

	task automatic checkBundle(input decoded_t e, input decoded_t a);
		checkField("Ra", 64'(e.Ra), 64'(a.Ra));
		checkField("Rb", 64'(e.Rb), 64'(a.Rb));
		checkField("Rc", 64'(e.Rc), 64'(a.Rc));
		checkField("Rcc", 64'(e.Rcc), 64'(a.Rcc));
		checkField("hasImma", 64'(e.hasImma), 64'(a.hasImma));
		checkField("hasImmb", 64'(e.hasImmb), 64'(a.hasImmb));
		checkField("hasImmc", 64'(e.hasImmc), 64'(a.hasImmc));
		checkField("immc", e.immc, a.immc);
	endtask

	// Full four-phase cycle, entered 1 ns after a rising edge
	task automatic sendWindow(input window_t w);
		int cnt;
		inWin = w;
		inReq = 1'b1;
		cnt = 0;
		while (inAck !== 1'b1 && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (inAck !== 1'b1)
			abortOnTimeout("inAck never rose for a pending window");
		inReq = 1'b0;
		cnt = 0;
		while (inAck !== 1'b0 && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (inAck !== 1'b0)
			abortOnTimeout("inAck stayed high after inReq dropped");
	endtask

	// ==================================================================
	// Comparator, samples on the falling edge where outputs are settled
	// ==================================================================
	always @(negedge clk) begin
		if (arstN === 1'b1 && outReq === 1'b1 && lastOutReq !== 1'b1) begin
			receivedCount++;
			if (expQ.size() == 0) begin
				$display("ERROR at %0t ns: a bundle arrived with no window outstanding", $time);
				errorCount++;
			end
			else begin
				expB = expQ.pop_front();
				checkBundle(expB, outBundle);
			end
		end
		lastOutReq = outReq;
	end

	// Output acknowledge with a random 0 to 3 cycle delay per bundle
	initial begin : ackDriver
		int          cnt;
		int          n;
		logic [31:0] rnd;
		cnt = 0;
		while (arstN !== 1'b1 && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (arstN !== 1'b1)
			abortOnTimeout("reset was never released");
		for (n = 0; n < NUM_WINDOWS; n++) begin
			cnt = 0;
			while (outReq !== 1'b1 && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (outReq !== 1'b1)
				abortOnTimeout("outReq never rose for the next bundle");
			rnd = $random(seed);
			repeat (rnd[1:0]) begin
				@(posedge clk);
				#1;
			end
			outAck = 1'b1;
			cnt = 0;
			while (outReq !== 1'b0 && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (outReq !== 1'b0)
				abortOnTimeout("outReq stayed high after outAck rose");
			outAck = 1'b0;
		end
	end

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin : mainSeq
		window_t w;
		int      n;
		int      cnt;
		arstN = 1'b0;
		inReq = 1'b0;
		inWin = '0;
		outAck = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
		// Both handshakes must come out of reset idle
		checkField("inAck", 64'd0, 64'(inAck));
		checkField("outReq", 64'd0, 64'(outReq));
		for (n = 0; n < NUM_WINDOWS; n++) begin
			makeWindow(w);
			expQ.push_back(refDecode(w));
			sendWindow(w);
		end
		cnt = 0;
		while (receivedCount < NUM_WINDOWS && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (receivedCount < NUM_WINDOWS)
			abortOnTimeout("not every window came back as a bundle");
		repeat (4) @(posedge clk);
		if (expQ.size() != 0) begin
			$display("ERROR: %0d expected bundles left in the queue", expQ.size());
			errorCount++;
		end
		if (receivedCount != NUM_WINDOWS) begin
			$display("ERROR: %0d bundles received for %0d windows sent",
				receivedCount, NUM_WINDOWS);
			errorCount++;
		end
		finishRun();
	end

endmodule
